//--- hdl/cmd_bus_pkg.sv
// command and response word layouts shared by the queues, arbiter and slaves
// referenced by scoped name from every RTL block on the command bus
package cmd_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus widths

  localparam int CMD_ADDR_W = 6;
  localparam int CMD_DATA_W = 32;

  // queue depths
  localparam int CMD_QUEUE_DEPTH  = 4;
  localparam int RESP_QUEUE_DEPTH = 4;

  //////////////////////////////////////////////////////////////////////
  // command word, 40 bits

  typedef struct packed {
    logic [CMD_ADDR_W-1:0] addr;
    logic [CMD_DATA_W-1:0] data;
    // host wants this command echoed back
    logic                  resprqst;
    logic                  is_alt;
  } cmd_t;

  //////////////////////////////////////////////////////////////////////
  // response word, 40 bits

  typedef struct packed {
    logic [CMD_ADDR_W-1:0] addr;
    // transmitter state when the command hit the bus
    logic                  tx_active;
    logic                  is_alt;
    logic [CMD_DATA_W-1:0] data;
  } resp_t;

endpackage

//--- hdl/radio_map_pkg.sv
// register address map of the command slaves and their configuration layouts
// slaves decode against these addresses, the top level exports the structs
package radio_map_pkg;

  // receivers
  localparam int NR = 4;

  //////////////////////////////////////////////////////////////////////
  // address map

  // data bit 0 is run
  localparam logic [cmd_bus_pkg::CMD_ADDR_W-1:0] ADDR_GENERAL  = 6'h00;
  localparam logic [cmd_bus_pkg::CMD_ADDR_W-1:0] ADDR_TX_FREQ  = 6'h01;
  // receiver n sits at ADDR_RX_FREQ0 + n
  localparam logic [cmd_bus_pkg::CMD_ADDR_W-1:0] ADDR_RX_FREQ0 = 6'h02;
  // data bits 7:0 are drive level
  localparam logic [cmd_bus_pkg::CMD_ADDR_W-1:0] ADDR_TX_DRIVE = 6'h09;
  // bits 5:0 lna gain, bit 6 transmit request
  localparam logic [cmd_bus_pkg::CMD_ADDR_W-1:0] ADDR_LNA      = 6'h0a;

  //////////////////////////////////////////////////////////////////////
  // radio configuration, 161 bits

  typedef struct packed {
    logic                                         run;
    logic [cmd_bus_pkg::CMD_DATA_W-1:0]           tx_freq;
    logic [NR-1:0][cmd_bus_pkg::CMD_DATA_W-1:0]   rx_freq;
  } radio_cfg_t;

  //////////////////////////////////////////////////////////////////////
  // rf frontend configuration, 16 bits

  typedef struct packed {
    logic [5:0] lna_gain;
    logic [7:0] tx_drive;
    logic       tx_request;
    // request gated by the inhibit input
    logic       tx_active;
  } frontend_cfg_t;

endpackage

//--- hdl/cmd_queue.sv
// small circular FIFO for any packed payload
// used for the host and link command queues and for the response queue
module cmd_queue #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = cmd_bus_pkg::CMD_QUEUE_DEPTH
) (
  input  logic     clk_ctrl,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t head_o,
  output logic     empty_o,
  output logic     full_o
);

  payload_t                     mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]     rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0]   count_q;
  logic [$clog2(DEPTH+1)-1:0]   count_next;
  logic                         empty_q;
  logic                         full_q;
  logic                         do_push;
  logic                         do_pop;

  // strobes against full/empty are dropped
  assign do_push = push_i & ~full_q;
  assign do_pop  = pop_i & ~empty_q;

  always_comb begin
    count_next = count_q;
    if (do_push && !do_pop) begin
      count_next = count_q + 1'b1;
    end else if (do_pop && !do_push) begin
      count_next = count_q - 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk_ctrl) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      empty_q  <= 1'b1;
      full_q   <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_next;
      empty_q <= (count_next == 0);
      full_q  <= (count_next == DEPTH);
    end
  end

  assign head_o  = mem[rd_ptr_q];
  assign empty_o = empty_q;
  assign full_o  = full_q;

endmodule

//--- hdl/cmd_arbiter.sv
// round-robin grant of the host and link queues onto the shared command bus
// bus and strobe are registered, one cycle after the queue pop
module cmd_arbiter (
  input  logic              clk_ctrl,
  input  logic              rst_n_i,
  input  cmd_bus_pkg::cmd_t host_head_i,
  input  logic              host_empty_i,
  input  cmd_bus_pkg::cmd_t link_head_i,
  input  logic              link_empty_i,
  input  logic              resp_stall_i,
  output logic              host_pop_o,
  output logic              link_pop_o,
  output cmd_bus_pkg::cmd_t cmd_bus_o,
  output logic              cmd_strobe_o
);

  cmd_bus_pkg::cmd_t cmd_bus_q;
  logic              cmd_strobe_q;
  // set when host had the last grant, reset favors host on first tie
  logic              last_host_q;
  logic              resp_inflight;
  logic              host_req;
  logic              link_req;
  logic              grant_host;
  logic              link_grant;

  // a response command on the bus has not reached the formatter yet,
  // so the queue full level cannot account for it
  assign resp_inflight = cmd_strobe_q & cmd_bus_q.resprqst;

  assign host_req = ~host_empty_i & ~resp_stall_i & ~resp_inflight;
  assign link_req = ~link_empty_i & ~resp_stall_i & ~resp_inflight;

  // alternate on contention
  assign grant_host = host_req & (~link_req | ~last_host_q);
  assign link_grant = link_req & ~grant_host;

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cmd_bus_q    <= '0;
      cmd_strobe_q <= 1'b0;
      last_host_q  <= 1'b0;
    end else begin
      cmd_strobe_q <= grant_host | link_grant;
      if (grant_host) begin
        cmd_bus_q   <= host_head_i;
        last_host_q <= 1'b1;
      end else if (link_grant) begin
        cmd_bus_q   <= link_head_i;
        last_host_q <= 1'b0;
      end
    end
  end

  assign host_pop_o   = grant_host;
  assign link_pop_o   = link_grant;
  assign cmd_bus_o    = cmd_bus_q;
  assign cmd_strobe_o = cmd_strobe_q;

endmodule

//--- hdl/radio_regs.sv
// command slave for radio run flag, transmit and receiver frequencies
// samples the command bus on strobe, outputs change one edge later
module radio_regs (
  input  logic                       clk_ctrl,
  input  logic                       rst_n_i,
  input  cmd_bus_pkg::cmd_t          cmd_bus_i,
  input  logic                       cmd_strobe_i,
  output radio_map_pkg::radio_cfg_t  radio_cfg_o
);

  radio_map_pkg::radio_cfg_t cfg_q;
  logic                      general_wr;
  logic                      tx_freq_wr;
  logic [radio_map_pkg::NR-1:0] rx_freq_wr;

  //////////////////////////////////////////////////////////////////////
  // address decode

  assign general_wr = cmd_strobe_i && (cmd_bus_i.addr == radio_map_pkg::ADDR_GENERAL);
  assign tx_freq_wr = cmd_strobe_i && (cmd_bus_i.addr == radio_map_pkg::ADDR_TX_FREQ);

  // one select per receiver
  always_comb begin
    for (int n = 0; n < radio_map_pkg::NR; n++) begin
      rx_freq_wr[n] = cmd_strobe_i &&
                      (cmd_bus_i.addr == radio_map_pkg::ADDR_RX_FREQ0 + n);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // registers

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q <= '0;
    end else begin
      if (general_wr) begin
        cfg_q.run <= cmd_bus_i.data[0];
      end
      if (tx_freq_wr) begin
        cfg_q.tx_freq <= cmd_bus_i.data;
      end
      for (int n = 0; n < radio_map_pkg::NR; n++) begin
        if (rx_freq_wr[n]) begin
          cfg_q.rx_freq[n] <= cmd_bus_i.data;
        end
      end
    end
  end

  assign radio_cfg_o = cfg_q;

endmodule

//--- hdl/frontend_regs.sv
// command slave for lna gain, transmit drive and transmit request
// tx_active follows the request unless the inhibit input is high
module frontend_regs (
  input  logic                          clk_ctrl,
  input  logic                          rst_n_i,
  input  cmd_bus_pkg::cmd_t             cmd_bus_i,
  input  logic                          cmd_strobe_i,
  input  logic                          tx_inhibit_i,
  output radio_map_pkg::frontend_cfg_t  frontend_cfg_o
);

  radio_map_pkg::frontend_cfg_t cfg_q;
  logic                         drive_wr;
  logic                         lna_wr;
  logic                         tx_request_d;

  assign drive_wr = cmd_strobe_i && (cmd_bus_i.addr == radio_map_pkg::ADDR_TX_DRIVE);
  assign lna_wr   = cmd_strobe_i && (cmd_bus_i.addr == radio_map_pkg::ADDR_LNA);

  // request as it will be after this edge
  assign tx_request_d = lna_wr ? cmd_bus_i.data[6] : cfg_q.tx_request;

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q <= '0;
    end else begin
      if (drive_wr) begin
        cfg_q.tx_drive <= cmd_bus_i.data[7:0];
      end
      if (lna_wr) begin
        cfg_q.lna_gain <= cmd_bus_i.data[5:0];
      end
      cfg_q.tx_request <= tx_request_d;
      // inhibit drops the transmitter on the next edge
      cfg_q.tx_active  <= tx_request_d & ~tx_inhibit_i;
    end
  end

  assign frontend_cfg_o = cfg_q;

endmodule

//--- hdl/resp_formatter.sv
// turns a strobed command that asks for a response into a response word
// the word is held one cycle and pushed into the response queue
module resp_formatter (
  input  logic                clk_ctrl,
  input  logic                rst_n_i,
  input  cmd_bus_pkg::cmd_t   cmd_bus_i,
  input  logic                cmd_strobe_i,
  input  logic                tx_active_i,
  output cmd_bus_pkg::resp_t  resp_o,
  output logic                resp_push_o
);

  cmd_bus_pkg::resp_t resp_q;
  logic               held_q;
  logic               capture;

  assign capture = cmd_strobe_i & cmd_bus_i.resprqst;

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_q <= '0;
      held_q <= 1'b0;
    end else begin
      held_q <= capture;
      if (capture) begin
        resp_q.addr      <= cmd_bus_i.addr;
        resp_q.tx_active <= tx_active_i;
        resp_q.is_alt    <= cmd_bus_i.is_alt;
        resp_q.data      <= cmd_bus_i.data;
      end
    end
  end

  assign resp_o      = resp_q;
  assign resp_push_o = held_q;

endmodule

//--- hdl/hl_cmd_core.sv
// command distribution core: host and link queues, arbiter, register slaves
// and the response path back to the host, all on clk_ctrl
module hl_cmd_core (
  input  logic                          clk_ctrl,
  input  logic                          rst_n_i,
  input  cmd_bus_pkg::cmd_t             host_cmd_i,
  input  logic                          host_valid_i,
  output logic                          host_full_o,
  input  cmd_bus_pkg::cmd_t             link_cmd_i,
  input  logic                          link_valid_i,
  output logic                          link_full_o,
  input  logic                          tx_inhibit_i,
  output radio_map_pkg::radio_cfg_t     radio_cfg_o,
  output radio_map_pkg::frontend_cfg_t  frontend_cfg_o,
  output cmd_bus_pkg::resp_t            resp_o,
  output logic                          resp_valid_o,
  input  logic                          resp_take_i
);

  cmd_bus_pkg::cmd_t  host_head;
  logic               host_empty;
  logic               host_pop;
  cmd_bus_pkg::cmd_t  link_head;
  logic               link_empty;
  logic               link_pop;
  cmd_bus_pkg::cmd_t  cmd_bus;
  logic               cmd_strobe;
  cmd_bus_pkg::resp_t resp_word;
  logic               resp_push;
  logic               resp_empty;
  logic               resp_full;
  logic               resp_stall;

  //////////////////////////////////////////////////////////////////////
  // command sources

  cmd_queue #(.payload_t(cmd_bus_pkg::cmd_t), .DEPTH(cmd_bus_pkg::CMD_QUEUE_DEPTH)) u_host_q (
    .clk_ctrl, .rst_n_i, .push_i(host_valid_i), .data_i(host_cmd_i), .pop_i(host_pop),
    .head_o(host_head), .empty_o(host_empty), .full_o(host_full_o)
  );

  cmd_queue #(.payload_t(cmd_bus_pkg::cmd_t), .DEPTH(cmd_bus_pkg::CMD_QUEUE_DEPTH)) u_link_q (
    .clk_ctrl, .rst_n_i, .push_i(link_valid_i), .data_i(link_cmd_i), .pop_i(link_pop),
    .head_o(link_head), .empty_o(link_empty), .full_o(link_full_o)
  );

  // response path back-pressure
  assign resp_stall = resp_full | resp_push;

  cmd_arbiter u_arbiter (
    .clk_ctrl, .rst_n_i,
    .host_head_i(host_head), .host_empty_i(host_empty),
    .link_head_i(link_head), .link_empty_i(link_empty),
    .resp_stall_i(resp_stall), .host_pop_o(host_pop), .link_pop_o(link_pop),
    .cmd_bus_o(cmd_bus), .cmd_strobe_o(cmd_strobe)
  );

  //////////////////////////////////////////////////////////////////////
  // slaves on the shared bus

  radio_regs u_radio_regs (
    .clk_ctrl, .rst_n_i, .cmd_bus_i(cmd_bus), .cmd_strobe_i(cmd_strobe),
    .radio_cfg_o(radio_cfg_o)
  );

  frontend_regs u_frontend_regs (
    .clk_ctrl, .rst_n_i, .cmd_bus_i(cmd_bus), .cmd_strobe_i(cmd_strobe),
    .tx_inhibit_i(tx_inhibit_i), .frontend_cfg_o(frontend_cfg_o)
  );

  //////////////////////////////////////////////////////////////////////
  // response to host

  resp_formatter u_resp_formatter (
    .clk_ctrl, .rst_n_i, .cmd_bus_i(cmd_bus), .cmd_strobe_i(cmd_strobe),
    .tx_active_i(frontend_cfg_o.tx_active), .resp_o(resp_word), .resp_push_o(resp_push)
  );

  cmd_queue #(.payload_t(cmd_bus_pkg::resp_t), .DEPTH(cmd_bus_pkg::RESP_QUEUE_DEPTH)) u_resp_q (
    .clk_ctrl, .rst_n_i, .push_i(resp_push), .data_i(resp_word), .pop_i(resp_take_i),
    .head_o(resp_o), .empty_o(resp_empty), .full_o(resp_full)
  );

  assign resp_valid_o = ~resp_empty;

endmodule

//--- bench/cmd_ref_model.svh
// reference model of the two register slaves and of the response words
// included inside the testbench module so the model state lives at module scope
`ifndef CMD_REF_MODEL_SVH
`define CMD_REF_MODEL_SVH

radio_map_pkg::radio_cfg_t    exp_radio;
radio_map_pkg::frontend_cfg_t exp_front;
logic                         model_inhibit;

function automatic void clear_model();
  exp_radio     = '0;
  exp_front     = '0;
  model_inhibit = 1'b0;
endfunction

// response as the host sees it before the command lands in the slaves
function automatic cmd_bus_pkg::resp_t predict_resp(cmd_bus_pkg::cmd_t c);
  cmd_bus_pkg::resp_t r;
  r.addr      = c.addr;
  r.tx_active = exp_front.tx_active;
  r.is_alt    = c.is_alt;
  r.data      = c.data;
  return r;
endfunction

// register map with run, tx freq, rx freq 0..3, drive and lna gain with tx request
function automatic void apply_cmd(cmd_bus_pkg::cmd_t c);
  int n;
  n = int'(c.addr) - 2;
  case (c.addr)
    6'h00: exp_radio.run = c.data[0];
    6'h01: exp_radio.tx_freq = c.data;
    6'h02, 6'h03, 6'h04, 6'h05: exp_radio.rx_freq[n] = c.data;
    6'h09: exp_front.tx_drive = c.data[7:0];
    6'h0a: begin
      exp_front.lna_gain   = c.data[5:0];
      exp_front.tx_request = c.data[6];
    end
    default: ;
  endcase
  exp_front.tx_active = exp_front.tx_request & ~model_inhibit;
endfunction

function automatic void track_inhibit(logic inhibit);
  model_inhibit       = inhibit;
  exp_front.tx_active = exp_front.tx_request & ~inhibit;
endfunction

`endif

//--- bench/tb_hl_cmd_core.sv
// random host and link traffic on the command core checked against a reference model
// covers response draining, back-pressure and transmit inhibit
module tb_hl_cmd_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SOLO_CMDS = 24;
  localparam int PAIR_CMDS = 32;
  localparam int FILL_CMDS = 12;
  localparam int NUM_CMDS  = SOLO_CMDS + PAIR_CMDS + FILL_CMDS + 1;

  logic                         clk_ctrl;
  logic                         rst_n_i;
  cmd_bus_pkg::cmd_t            host_cmd_i;
  logic                         host_valid_i;
  logic                         host_full_o;
  cmd_bus_pkg::cmd_t            link_cmd_i;
  logic                         link_valid_i;
  logic                         link_full_o;
  logic                         tx_inhibit_i;
  radio_map_pkg::radio_cfg_t    radio_cfg_o;
  radio_map_pkg::frontend_cfg_t frontend_cfg_o;
  cmd_bus_pkg::resp_t           resp_o;
  logic                         resp_valid_o;
  logic                         resp_take_i;

  logic [31:0]        rng_state = 32'h25ea_3223;
  cmd_bus_pkg::resp_t exp_resp[$];
  int                 errors = 0;
  int                 checks = 0;
  int                 resp_seen = 0;
  int                 resp_sent = 0;
  logic               take_enable = 1'b1;
  // high when the host had the last grant
  logic               last_host = 1'b0;

  `include "cmd_ref_model.svh"

  hl_cmd_core u_hl_cmd_core (.*);

  initial begin
    clk_ctrl = 1'b0;
    forever #50 clk_ctrl = ~clk_ctrl;
  end

  // watchdog sized from the command count
  initial begin
    repeat (NUM_CMDS * 20 + 200) @(posedge clk_ctrl);
    $display("timeout: traffic did not finish within %0d cycles", NUM_CMDS * 20 + 200);
    $display("errors: %0d of %0d checks", errors, checks);
    $display("Simulation FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] rand_next();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // mostly mapped addresses and now and then any address in the space
  function automatic cmd_bus_pkg::cmd_t random_cmd();
    cmd_bus_pkg::cmd_t c;
    logic [31:0]       r;
    r = rand_next();
    c.addr = (r[6:4] < 3'd6) ? {3'b000, r[6:4]} : {3'b000, r[6:4]} + 6'd3;
    if (r[3:0] > 4'd11) begin
      c.addr = r[13:8];
    end
    c.data     = rand_next();
    c.resprqst = r[16];
    c.is_alt   = r[17];
    return c;
  endfunction

  task automatic check_value(string name, logic [191:0] got, logic [191:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0d ns: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(string what);
    errors++;
    $display("error at %0d ns: %s", $time, what);
  endtask

  function automatic void expect_cmd(cmd_bus_pkg::cmd_t c);
    if (c.resprqst) begin
      exp_resp.push_back(predict_resp(c));
      resp_sent++;
    end
    apply_cmd(c);
  endfunction

  // only used while the link queue is idle
  task automatic send_host(cmd_bus_pkg::cmd_t c);
    while (host_full_o) begin
      @(negedge clk_ctrl);
    end
    expect_cmd(c);
    last_host    = 1'b1;
    host_cmd_i   = c;
    host_valid_i = 1'b1;
    @(negedge clk_ctrl);
    host_valid_i = 1'b0;
  endtask

  // both sources strobe together and the round-robin picks the one not granted last
  task automatic send_pair(cmd_bus_pkg::cmd_t h, cmd_bus_pkg::cmd_t l);
    while (host_full_o || link_full_o) begin
      @(negedge clk_ctrl);
    end
    // the second grant goes back to the source granted last before the pair
    if (last_host) begin
      expect_cmd(l);
      expect_cmd(h);
    end else begin
      expect_cmd(h);
      expect_cmd(l);
    end
    host_cmd_i   = h;
    link_cmd_i   = l;
    host_valid_i = 1'b1;
    link_valid_i = 1'b1;
    @(negedge clk_ctrl);
    host_valid_i = 1'b0;
    link_valid_i = 1'b0;
  endtask

  // wait for the source queues and expected responses to drain and two idle cycles
  task automatic settle();
    int waited;
    waited = 0;
    while (!(u_hl_cmd_core.host_empty && u_hl_cmd_core.link_empty &&
             exp_resp.size() == 0) && waited < 200) begin
      @(negedge clk_ctrl);
      waited++;
    end
    if (waited == 200) begin
      report_failure("command queues or responses did not drain");
    end
    repeat (2) @(negedge clk_ctrl);
    check_value("radio_cfg_o", radio_cfg_o, exp_radio);
    check_value("frontend_cfg_o", frontend_cfg_o, exp_front);
  endtask

  // host side of the response queue
  initial begin
    resp_take_i = 1'b0;
    forever begin
      @(negedge clk_ctrl);
      resp_take_i = 1'b0;
      if (rst_n_i && take_enable && resp_valid_o) begin
        resp_take_i = 1'b1;
        resp_seen++;
        if (exp_resp.size() == 0) begin
          report_failure("response arrived with no command waiting for one");
        end else begin
          check_value("resp_o", resp_o, exp_resp.pop_front());
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    cmd_bus_pkg::cmd_t h;
    cmd_bus_pkg::cmd_t l;
    rst_n_i      = 1'b0;
    host_cmd_i   = '0;
    host_valid_i = 1'b0;
    link_cmd_i   = '0;
    link_valid_i = 1'b0;
    tx_inhibit_i = 1'b0;
    clear_model();
    repeat (4) @(posedge clk_ctrl);
    @(negedge clk_ctrl);
    rst_n_i = 1'b1;
    check_value("host_full_o", host_full_o, 1'b0);
    check_value("link_full_o", link_full_o, 1'b0);
    check_value("resp_valid_o", resp_valid_o, 1'b0);
    check_value("radio_cfg_o", radio_cfg_o, exp_radio);
    check_value("frontend_cfg_o", frontend_cfg_o, exp_front);
    // host alone in bursts of 8
    for (int i = 0; i < SOLO_CMDS; i++) begin
      send_host(random_cmd());
      if (i % 8 == 7) begin
        settle();
      end
    end
    // host and link together on different addresses
    for (int i = 0; i < PAIR_CMDS / 2; i++) begin
      h = random_cmd();
      l = random_cmd();
      while (l.addr == h.addr) begin
        l = random_cmd();
      end
      send_pair(h, l);
      if (i % 8 == 7) begin
        settle();
      end
    end
    // responses held back until the source queues fill
    take_enable = 1'b0;
    for (int i = 0; i < FILL_CMDS / 2; i++) begin
      h = random_cmd();
      l = random_cmd();
      while (l.addr == h.addr) begin
        l = random_cmd();
      end
      h.resprqst = 1'b1;
      l.resprqst = 1'b1;
      send_pair(h, l);
    end
    repeat (50) begin
      if (!(host_full_o && link_full_o)) begin
        @(negedge clk_ctrl);
      end
    end
    if (!(host_full_o && link_full_o)) begin
      report_failure("source full levels never rose while responses were held");
    end
    check_value("resp_valid_o", resp_valid_o, 1'b1);
    take_enable = 1'b1;
    settle();
    check_value("response count", resp_seen, resp_sent);
    // transmit request followed by inhibit on and off
    h          = '0;
    h.addr     = 6'h0a;
    h.data     = 32'h40 | (rand_next() & 32'h3f);
    send_host(h);
    settle();
    tx_inhibit_i = 1'b1;
    track_inhibit(1'b1);
    repeat (2) @(negedge clk_ctrl);
    check_value("frontend_cfg_o", frontend_cfg_o, exp_front);
    tx_inhibit_i = 1'b0;
    track_inhibit(1'b0);
    repeat (2) @(negedge clk_ctrl);
    check_value("frontend_cfg_o", frontend_cfg_o, exp_front);
    $display("errors: %0d of %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+bench
hdl/cmd_bus_pkg.sv
hdl/radio_map_pkg.sv
hdl/cmd_queue.sv
hdl/cmd_arbiter.sv
hdl/radio_regs.sv
hdl/frontend_regs.sv
hdl/resp_formatter.sv
hdl/hl_cmd_core.sv
bench/tb_hl_cmd_core.sv

//--- run_sim.sh
#!/bin/sh
# build the command core testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  -f sources.f --top-module tb_hl_cmd_core -o sim_hl_cmd_core

./obj_dir/sim_hl_cmd_core > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation PASSED" sim.log; then
  exit 0
fi
exit 1
